//--- rd_addr_decoder.sv
// Address decoder for the AR channel of the read demux.
// Compares the request address with every slave's base and mask and
// returns the index of the first slave that matches.
// An address outside the map falls back to slave 0.

module rd_addr_decoder
    import rd_demux_pkg::*;
(
    input  addr_t      addr,
    output slave_idx_t target
);

    // One bit per slave, set when the address lies inside that slave's window
    logic [NUM_SLAVES-1:0] match;

    always_comb begin
        // A zero mask disables the slave entirely
        for (int i = 0; i < NUM_SLAVES; i++) begin
            match[i] = (SLAVE_MASK[i] != '0) &&
                       ((addr & ~SLAVE_MASK[i]) == SLAVE_BASE[i]);
        end

        // Scan from the top so that the lowest matching index is the one left behind
        // With no match at all the default of slave 0 stands
        target = '0;
        for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
            if (match[i]) begin
                target = slave_idx_t'(i);
            end
        end

        // The windows of the address map must not overlap
        // An unknown address before the master starts driving is not a map fault
        assert ($onehot0(match) || $isunknown(addr))
            else $error("address %h matches more than one slave (%b)", addr, match);
    end

endmodule

//--- rd_ar_ctrl.sv
// AR channel control of the read demux.
// Locks an admitted request onto one slave and keeps that slave's valid
// high until the slave accepts it. The slave's ready goes straight back to
// the master, so a request costs one cycle of latency and one bubble.

module rd_ar_ctrl
    import rd_demux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  logic                  admit,
    input  slave_idx_t            target,
    output logic [NUM_SLAVES-1:0] s_ar_valid,
    input  logic [NUM_SLAVES-1:0] s_ar_ready,
    output logic                  ar_fire,
    output slave_idx_t            sel_slave
);

    // Set from the admit edge until the transfer edge
    logic lock_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lock_q    <= 1'b0;
            sel_slave <= '0;
        end else if (lock_q) begin
            // The master keeps valid high while locked, so ready alone marks the transfer
            if (ar_fire) begin
                lock_q <= 1'b0;
            end
        end else if (ar_valid && admit) begin
            lock_q    <= 1'b1;
            sel_slave <= target;
        end
    end

    // Only the selected slave sees the request
    for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_strobe
        assign s_ar_valid[g] = lock_q && (sel_slave == slave_idx_t'(g));
    end

    // Ready comes back from whichever slave holds the lock
    assign ar_ready = lock_q && s_ar_ready[sel_slave];
    assign ar_fire  = ar_valid && ar_ready;

    // A master that drops a request after it was routed would leave a slave
    // holding a request nobody owns, and the ordering table would miss the burst
    a_valid_held : assert property (@(posedge clk) disable iff (!rstn)
        lock_q |-> ar_valid)
        else $error("ar_valid dropped while a request was locked to slave %0d", sel_slave);

endmodule

//--- rd_demux_pkg.sv
// Shared widths, slave address map, counter limits and types for the read demux.
// Every design module takes this package by a wildcard import in its header.
// The address map is fixed here and gives each slave one quarter of the space.

package rd_demux_pkg;

    // Slave count and the width of a slave index
    localparam int NUM_SLAVES = 4;
    localparam int SLAVE_W    = 2;

    // Id space of the master
    localparam int ID_W    = 4;
    localparam int NUM_IDS = 1 << ID_W;

    // Channel field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;
    localparam int RESP_W = 2;

    // Outstanding bursts per id are counted in CNT_W bits and capped at CNT_MAX
    localparam int CNT_W   = 3;
    localparam int CNT_MAX = 7;

    // Slave i owns the addresses whose top two bits equal i
    // The mask marks the bits that are ignored by the match
    localparam logic [NUM_SLAVES-1:0][ADDR_W-1:0] SLAVE_BASE = {
        32'hC000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0000_0000
    };
    localparam logic [NUM_SLAVES-1:0][ADDR_W-1:0] SLAVE_MASK = {
        32'h3FFF_FFFF, 32'h3FFF_FFFF, 32'h3FFF_FFFF, 32'h3FFF_FFFF
    };

    typedef logic [SLAVE_W-1:0] slave_idx_t;
    typedef logic [ID_W-1:0]    id_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [RESP_W-1:0]  resp_t;

    // One entry of the per-id ordering table
    typedef struct packed {
        slave_idx_t       slave;
        logic [CNT_W-1:0] cnt;
    } order_entry_t;

endpackage

//--- rd_demux_top.sv
// Top level of the read demux with one master and NUM_SLAVES slaves.
// Routes AR requests by address, keeps per-id ordering and arbitrates
// R beats back to the master. The master's AR fields are shared by all
// slaves and only the valid strobe is per slave.

module rd_demux_top
    import rd_demux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,

    // Master AR channel
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  id_t                   ar_id,
    input  addr_t                 ar_addr,
    input  len_t                  ar_len,

    // Master R channel
    output logic                  r_valid,
    input  logic                  r_ready,
    output id_t                   r_id,
    output data_t                 r_data,
    output resp_t                 r_resp,
    output logic                  r_last,

    // Slave AR channels
    output logic [NUM_SLAVES-1:0] s_ar_valid,
    input  logic [NUM_SLAVES-1:0] s_ar_ready,
    output id_t                   s_ar_id,
    output addr_t                 s_ar_addr,
    output len_t                  s_ar_len,

    // Slave R channels
    input  logic [NUM_SLAVES-1:0] s_r_valid,
    output logic [NUM_SLAVES-1:0] s_r_ready,
    input  id_t                   s_r_id   [NUM_SLAVES],
    input  data_t                 s_r_data [NUM_SLAVES],
    input  resp_t                 s_r_resp [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0] s_r_last
);

    slave_idx_t target;
    slave_idx_t sel_slave;
    logic       admit;
    logic       ar_fire;
    logic       r_fire;

    // Request fields reach every slave unchanged
    assign s_ar_id   = ar_id;
    assign s_ar_addr = ar_addr;
    assign s_ar_len  = ar_len;

    rd_addr_decoder u_decoder (
        .addr   (ar_addr),
        .target (target)
    );

    // The table sees the master side of both channels
    rd_id_order_table u_order_table (
        .clk        (clk),
        .rstn       (rstn),
        .ar_id      (ar_id),
        .target     (target),
        .admit      (admit),
        .ar_fire    (ar_fire),
        .fire_slave (sel_slave),
        .r_fire     (r_fire),
        .r_id       (r_id),
        .r_last     (r_last)
    );

    rd_ar_ctrl u_ar_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .admit      (admit),
        .target     (target),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .ar_fire    (ar_fire),
        .sel_slave  (sel_slave)
    );

    rd_resp_arbiter u_resp_arbiter (
        .clk       (clk),
        .rstn      (rstn),
        .r_ready   (r_ready),
        .s_r_valid (s_r_valid),
        .s_r_ready (s_r_ready),
        .s_r_id    (s_r_id),
        .s_r_data  (s_r_data),
        .s_r_resp  (s_r_resp),
        .s_r_last  (s_r_last),
        .r_valid   (r_valid),
        .r_id      (r_id),
        .r_data    (r_data),
        .r_resp    (r_resp),
        .r_last    (r_last),
        .r_fire    (r_fire)
    );

endmodule

//--- rd_id_order_table.sv
// Per-id ordering table of the read demux.
// Each id remembers the slave it is bound to and how many of its bursts are
// still outstanding there. A new request is admitted only if it keeps the
// id on one slave and stays under the outstanding limit.

module rd_id_order_table
    import rd_demux_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  id_t        ar_id,
    input  slave_idx_t target,
    output logic       admit,
    input  logic       ar_fire,
    input  slave_idx_t fire_slave,
    input  logic       r_fire,
    input  id_t        r_id,
    input  logic       r_last
);

    order_entry_t table_q [NUM_IDS];
    order_entry_t lookup;

    // Per-id strobes for a new burst and for a closed burst
    logic [NUM_IDS-1:0] inc;
    logic [NUM_IDS-1:0] dec;

    assign lookup = table_q[ar_id];

    // An idle id may go anywhere
    // A busy id may only follow its earlier bursts and only below the limit
    assign admit = (lookup.cnt == '0) ||
                   ((lookup.slave == target) && (lookup.cnt < CNT_W'(CNT_MAX)));

    for (genvar g = 0; g < NUM_IDS; g++) begin : g_strobe
        assign inc[g] = ar_fire && (ar_id == id_t'(g));
        // Only the last beat of a burst closes it
        assign dec[g] = r_fire && r_last && (r_id == id_t'(g));
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                table_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_IDS; i++) begin
                if (inc[i]) begin
                    table_q[i].slave <= fire_slave;
                    // A burst opening and one closing in the same cycle cancel out
                    if (!dec[i]) begin
                        table_q[i].cnt <= table_q[i].cnt + 1'b1;
                    end
                end else if (dec[i]) begin
                    table_q[i].cnt <= table_q[i].cnt - 1'b1;
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_IDS; g++) begin : g_chk
        // The admission check upstream must stop a full id before it reaches a slave
        a_no_overflow : assert property (@(posedge clk) disable iff (!rstn)
            !(inc[g] && !dec[g] && (table_q[g].cnt == CNT_W'(CNT_MAX))))
            else $error("id %0d exceeds the outstanding limit", g);

        // A closing beat for an id with nothing outstanding means a slave misbehaved
        a_no_underflow : assert property (@(posedge clk) disable iff (!rstn)
            !(dec[g] && (table_q[g].cnt == '0)))
            else $error("id %0d closed a burst that was never issued", g);
    end

endmodule

//--- rd_resp_arbiter.sv
// R channel arbiter of the read demux.
// Picks one slave beat per cycle by rotating priority and multiplexes it
// onto the master channel with no added latency. Arbitration only happens
// while the master is ready, so every beat shown is taken in the same cycle.

module rd_resp_arbiter
    import rd_demux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  r_ready,
    input  logic [NUM_SLAVES-1:0] s_r_valid,
    output logic [NUM_SLAVES-1:0] s_r_ready,
    input  id_t                   s_r_id   [NUM_SLAVES],
    input  data_t                 s_r_data [NUM_SLAVES],
    input  resp_t                 s_r_resp [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0] s_r_last,
    output logic                  r_valid,
    output id_t                   r_id,
    output data_t                 r_data,
    output resp_t                 r_resp,
    output logic                  r_last,
    output logic                  r_fire
);

    // First slave looked at in the next arbitration
    slave_idx_t ptr_q;

    // One-hot grant and the same grant as an index
    logic [NUM_SLAVES-1:0] grant;
    slave_idx_t            grant_idx;

    always_comb begin
        slave_idx_t idx;
        logic       found;

        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        idx       = '0;
        // The index wraps in SLAVE_W bits, which suits a power-of-two slave count
        for (int k = 0; k < NUM_SLAVES; k++) begin
            idx = ptr_q + slave_idx_t'(k);
            if (!found && r_ready && s_r_valid[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                grant_idx  = idx;
            end
        end
    end

    // Grant already includes r_ready, so ready and valid rise together
    assign s_r_ready = grant;
    assign r_valid   = |grant;
    assign r_fire    = r_valid && r_ready;

    // The granted slave's fields go to the master
    assign r_id   = s_r_id[grant_idx];
    assign r_data = s_r_data[grant_idx];
    assign r_resp = s_r_resp[grant_idx];
    assign r_last = s_r_last[grant_idx];

    // The winner drops to lowest priority once its beat has gone
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr_q <= '0;
        end else if (r_fire) begin
            ptr_q <= grant_idx + 1'b1;
        end
    end

    // Two slaves released together would both believe their beat was taken
    a_grant_onehot : assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(s_r_ready))
        else $error("more than one slave granted on R (%b)", s_r_ready);

endmodule

//--- run.sh
#!/bin/sh
# Builds the read demux testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_rd_demux -o tb_rd_demux_sim

./obj_dir/tb_rd_demux_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: testbench passed"
    exit 0
else
    echo "run.sh: testbench reported failure"
    exit 1
fi

//--- sim.f
rd_demux_pkg.sv
rd_addr_decoder.sv
rd_id_order_table.sv
rd_ar_ctrl.sv
rd_resp_arbiter.sv
rd_demux_top.sv
tb_rd_demux.sv

//--- tb_rd_demux.sv
// Testbench for the read demux with four slave models and a random master.
// Requests are checked for routing, per-id ordering and the outstanding limit.
// R beats are checked against a reference model of the expected bursts.
// The run ends with one summary line and a pass or fail message.

module tb_rd_demux
    import rd_demux_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 20000;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  ar_valid;
    logic                  ar_ready;
    id_t                   ar_id;
    addr_t                 ar_addr;
    len_t                  ar_len;
    logic                  r_valid;
    logic                  r_ready;
    id_t                   r_id;
    data_t                 r_data;
    resp_t                 r_resp;
    logic                  r_last;
    logic [NUM_SLAVES-1:0] s_ar_valid;
    logic [NUM_SLAVES-1:0] s_ar_ready;
    id_t                   s_ar_id;
    addr_t                 s_ar_addr;
    len_t                  s_ar_len;
    logic [NUM_SLAVES-1:0] s_r_valid;
    logic [NUM_SLAVES-1:0] s_r_ready;
    id_t                   s_r_id   [NUM_SLAVES];
    data_t                 s_r_data [NUM_SLAVES];
    resp_t                 s_r_resp [NUM_SLAVES];
    logic [NUM_SLAVES-1:0] s_r_last;

    // Slave models keep {id, addr, len} per accepted burst, in order
    logic [43:0] slave_q [NUM_SLAVES][$];
    int          sbeat      [NUM_SLAVES];
    logic        presenting [NUM_SLAVES];
    int          skips      [NUM_SLAVES];

    // Expected bursts {addr, len} per id and the testbench's own outstanding count
    logic [39:0] exp_q [NUM_IDS][$];
    int          exp_beat  [NUM_IDS];
    int          out_cnt   [NUM_IDS];
    int          out_slave [NUM_IDS];

    // Run control for the stimulus processes
    logic run;
    logic hold_resp;
    logic dense;
    logic force_rready;
    logic ar_done;
    int   errors;
    int   checks;

    always #2 clk = ~clk;

    rd_demux_top dut (.*);

    // Beat contents that a slave returns, tagged with the slave's own index
    function automatic logic [33:0] beat_word(int slv, id_t id, addr_t addr, int beat);
        data_t data;
        resp_t resp;
        data = addr + data_t'(beat * 4);
        data = data ^ {slave_idx_t'(slv), 6'h2A, 4'h0, id, 8'h00, 8'(beat)};
        resp = resp_t'(slv + beat);
        return {resp, data};
    endfunction

    // The address map gives each slave the addresses whose top two bits equal its index
    function automatic int ref_slave(addr_t addr);
        return int'(addr[ADDR_W-1 -: SLAVE_W]);
    endfunction

    // Expected {resp, data} of one beat, as the slave chosen by the map would return it
    function automatic logic [33:0] ref_beat(addr_t addr, id_t id, int beat);
        return beat_word(ref_slave(addr), id, addr, beat);
    endfunction

    function automatic logic all_drained();
        logic idle;
        idle = !ar_valid;
        for (int i = 0; i < NUM_IDS; i++) begin
            idle = idle && (exp_q[i].size() == 0);
        end
        for (int i = 0; i < NUM_SLAVES; i++) begin
            idle = idle && (slave_q[i].size() == 0);
        end
        return idle;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timeout at %0t: no %s within the cycle limit", $time, what);
        finish_run();
    endtask

    // Called on a falling edge, holds the request until the monitor sees it taken
    task automatic drive_request(input id_t id, input addr_t addr, input len_t len);
        ar_valid = 1'b1;
        ar_id    = id;
        ar_addr  = addr;
        ar_len   = len;
        ar_done  = 1'b0;
    endtask

    task automatic wait_request_taken();
        int cycles;
        cycles = 0;
        while (!ar_done) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_on_timeout("AR handshake");
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic send_request(input id_t id, input addr_t addr, input len_t len);
        @(negedge clk);
        drive_request(id, addr, len);
        wait_request_taken();
        @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (!all_drained()) begin
            if (cycles >= DRAIN_LIMIT) begin
                stop_on_timeout("drain of outstanding bursts");
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    // Master r_ready and the four slave models, all driven on the falling edge
    always @(negedge clk) begin
        logic [43:0] sb;
        logic [33:0] word;
        if (run) begin
            r_ready = force_rready || (($urandom % 4) != 0);
            for (int i = 0; i < NUM_SLAVES; i++) begin
                s_ar_ready[i] = ($urandom % 4) != 0;
                // A beat on show stays put until the monitor sees it taken
                if (!presenting[i]) begin
                    if (slave_q[i].size() != 0 && !hold_resp &&
                        (dense || ($urandom % 3) != 0)) begin
                        sb            = slave_q[i][0];
                        word          = beat_word(i, sb[43:40], sb[39:8], sbeat[i]);
                        s_r_valid[i]  = 1'b1;
                        s_r_id[i]     = sb[43:40];
                        s_r_data[i]   = word[31:0];
                        s_r_resp[i]   = word[33:32];
                        s_r_last[i]   = (sbeat[i] == int'(sb[7:0]));
                        presenting[i] = 1'b1;
                    end else begin
                        s_r_valid[i] = 1'b0;
                    end
                end
            end
        end
    end

    // Compare process, sampling between the falling edge and the transfer edge
    always begin
        logic [NUM_SLAVES-1:0] s_fire;
        logic [43:0]           sb;
        logic [39:0]           eb;
        logic [33:0]           word;
        int                    slv;
        int                    grant;
        @(negedge clk);
        #1;
        if (run) begin
            s_fire = s_ar_valid & s_ar_ready;
            slv    = 0;
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if (s_fire[i]) slv = i;
            end
            if (s_fire != '0) begin
                check_value("s_ar transfer one-hot", 64'($onehot(s_fire)), 1);
                check_value("ar_valid && ar_ready", 64'(ar_valid && ar_ready), 1);
                check_value("s_ar slave", slv, ref_slave(ar_addr));
                check_value("s_ar_id", s_ar_id, ar_id);
                check_value("s_ar_addr", s_ar_addr, ar_addr);
                check_value("s_ar_len", s_ar_len, ar_len);
                // An id with bursts in flight must stay on the slave it is bound to
                if (out_cnt[ar_id] != 0) begin
                    check_value("s_ar slave of busy id", slv, out_slave[ar_id]);
                end
                check_value("outstanding below CNT_MAX", 64'(out_cnt[ar_id] < CNT_MAX), 1);
                slave_q[slv].push_back({s_ar_id, s_ar_addr, s_ar_len});
                exp_q[ar_id].push_back({ar_addr, ar_len});
                out_cnt[ar_id]++;
                out_slave[ar_id] = slv;
                ar_done = 1'b1;
            end else if (ar_valid && ar_ready) begin
                errors++;
                $display("AR request taken at %0t without reaching any slave", $time);
            end

            if (r_valid) begin
                check_value("r_ready while r_valid", r_ready, 1);
            end
            if (r_valid && r_ready) begin
                check_value("s_r_ready one-hot", 64'($onehot(s_r_ready)), 1);
                grant = 0;
                for (int i = 0; i < NUM_SLAVES; i++) begin
                    if (s_r_ready[i]) grant = i;
                end
                check_value("s_r_valid of granted slave", s_r_valid[grant], 1);
                if (exp_q[r_id].size() == 0) begin
                    errors++;
                    $display("R beat at %0t for id %0d with no burst outstanding", $time, r_id);
                end else begin
                    eb   = exp_q[r_id][0];
                    word = ref_beat(eb[39:8], r_id, exp_beat[r_id]);
                    check_value("r_data", r_data, word[31:0]);
                    check_value("r_resp", r_resp, word[33:32]);
                    check_value("r_last", r_last, 64'(exp_beat[r_id] == int'(eb[7:0])));
                    if (exp_beat[r_id] == int'(eb[7:0])) begin
                        void'(exp_q[r_id].pop_front());
                        exp_beat[r_id] = 0;
                        out_cnt[r_id]--;
                    end else begin
                        exp_beat[r_id]++;
                    end
                end
                // The granted slave moves on to its next beat
                presenting[grant] = 1'b0;
                if (slave_q[grant].size() != 0) begin
                    sb = slave_q[grant][0];
                    // The beat carries the id of the burst that slave is working on
                    check_value("r_id", r_id, sb[43:40]);
                    if (sbeat[grant] == int'(sb[7:0])) begin
                        void'(slave_q[grant].pop_front());
                        sbeat[grant] = 0;
                    end else begin
                        sbeat[grant]++;
                    end
                end
            end else begin
                check_value("s_r_ready without a transfer", s_r_ready, 0);
            end

            // Round robin lets at most NUM_SLAVES-1 other beats pass a waiting slave
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if (!s_r_valid[i] || s_r_ready[i]) begin
                    skips[i] = 0;
                end else if (r_valid && r_ready) begin
                    skips[i]++;
                    check_value($sformatf("beats passed over slave %0d", i),
                                64'(skips[i] < NUM_SLAVES), 1);
                end
            end
        end
    end

    initial begin
        int idle;
        void'($urandom(32'h9297_f087));
        rstn         = 1'b0;
        run          = 1'b0;
        hold_resp    = 1'b0;
        dense        = 1'b0;
        force_rready = 1'b0;
        ar_done      = 1'b0;
        errors       = 0;
        checks       = 0;
        ar_valid     = 1'b0;
        ar_id        = '0;
        ar_addr      = '0;
        ar_len       = '0;
        r_ready      = 1'b0;
        s_ar_ready   = '0;
        s_r_valid    = '0;
        s_r_last     = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_r_id[i]     = '0;
            s_r_data[i]   = '0;
            s_r_resp[i]   = '0;
            presenting[i] = 1'b0;
            sbeat[i]      = 0;
            skips[i]      = 0;
        end
        for (int i = 0; i < NUM_IDS; i++) begin
            exp_beat[i]  = 0;
            out_cnt[i]   = 0;
            out_slave[i] = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;
        check_value("ar_ready after reset", ar_ready, 0);
        check_value("r_valid after reset", r_valid, 0);
        check_value("s_ar_valid after reset", s_ar_valid, 0);
        check_value("s_r_ready after reset", s_r_ready, 0);
        run = 1'b1;

        // Random traffic over four ids, so that ids often meet at different slaves
        for (int n = 0; n < 300; n++) begin
            idle = $urandom % 3;
            repeat (idle) @(negedge clk);
            send_request(id_t'($urandom % 4), {slave_idx_t'($urandom % 4), 30'($urandom)},
                         len_t'($urandom % 4));
        end
        wait_drained();

        // Fill id 5 up to the limit with responses held, then try one more
        @(negedge clk);
        hold_resp = 1'b1;
        for (int n = 0; n < CNT_MAX; n++) begin
            send_request(id_t'(5), addr_t'(32'h4000_0000 + n * 64), len_t'(n % 3));
        end
        @(negedge clk);
        drive_request(id_t'(5), addr_t'(32'h4000_1000), len_t'(2));
        repeat (24) @(posedge clk);
        check_value("AR taken over the limit", ar_done, 0);
        @(negedge clk);
        // A full id must not even be offered to its slave
        check_value("s_ar_valid while id 5 is full", s_ar_valid, 0);
        hold_resp = 1'b0;
        wait_request_taken();
        @(negedge clk);
        ar_valid = 1'b0;
        wait_drained();

        // Every slave holds a long burst, then all are released into a ready master
        @(negedge clk);
        hold_resp = 1'b1;
        dense     = 1'b1;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            send_request(id_t'(8 + s), {slave_idx_t'(s), 30'h100}, len_t'(7));
        end
        @(negedge clk);
        force_rready = 1'b1;
        hold_resp    = 1'b0;
        wait_drained();

        finish_run();
    end

endmodule
